// ==== src/loader_pkg.sv ====
// Shared definitions for the media image loader
// Address width, download byte and memory write records
// Image kind enum and cartridge header records
// CRT layout constants and the BASIC pointer address list

package loader_pkg;

	// ========================================================================
	// Widths and records
	// ========================================================================

	// Memory address width, also the width of the download offset
	localparam int ADDR_W = 25;

	typedef struct packed {
		logic [ADDR_W-1:0] offset;
		logic [7:0]        data;
	} dl_byte_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_wr_t;

	// Index 4 is a program file, 5 and 0xC0 are cartridges
	typedef enum logic [1:0] {
		IMG_NONE,
		IMG_PRG,
		IMG_CRT
	} image_kind_e;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	typedef struct packed {
		logic [7:0]        chip_type;
		logic [15:0]       bank;
		logic [15:0]       load_addr;
		logic [15:0]       size;
		logic [ADDR_W-1:0] base;
	} bank_rec_t;

	// ========================================================================
	// Image layout constants
	// ========================================================================

	// First chip packet follows the 64 byte file header
	localparam logic [ADDR_W-1:0] CRT_HDR_END = 25'h40;
	localparam int CHIP_HDR_LEN = 16;
	// Each packet starts on an 8 KB boundary
	localparam int BANK_ALIGN_W = 13;

	// Page zero pointers set after a program load
	localparam int BASIC_PTR_COUNT = 12;
	localparam logic [7:0] BASIC_PTR_ADDR [BASIC_PTR_COUNT] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E, 8'h2F, 8'h30,
		8'h31, 8'h32, 8'hAC, 8'hAD, 8'hAE, 8'hAF
	};

endpackage

// ==== src/image_parser.sv ====
// Download parser for program and cartridge images
// Index decode into the image kind
// PRG load address and end address tracking
// CRT file header and chip packet header parsing
// Write address generation with 8 KB bank alignment
// One registered write towards the memory port

module image_parser
	import loader_pkg::*;
#(
	parameter logic [ADDR_W-1:0] CRT_BASE = 25'h100000
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              dl_active_i,
	input  logic [7:0]        dl_index_i,
	input  logic              dl_valid_i,
	input  dl_byte_t          dl_byte_i,
	output logic              dl_ready_o,
	output logic              pw_valid_o,
	output mem_wr_t           pw_wr_o,
	input  logic              pw_ready_i,
	output logic              prg_done_o,
	output logic [15:0]       prg_end_o,
	output cart_info_t        cart_info_o,
	output logic              cart_attached_o,
	output bank_rec_t         bank_rec_o,
	output logic              bank_valid_o
);

	image_kind_e       kind;
	logic [ADDR_W-1:0] dl_off;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] aligned_addr;
	logic              accept;
	logic              active_q;
	logic              dl_rise;
	logic              dl_fall;
	logic              crt_body;
	logic              pkt_start;
	logic              in_chip_hdr;
	logic              data_byte;
	logic [3:0]        hdr_cnt;
	logic [31:0]       blk_left;

	always_comb begin
		case (dl_index_i)
			8'h04:        kind = IMG_PRG;
			8'h05, 8'hC0: kind = IMG_CRT;
			default:      kind = IMG_NONE;
		endcase
	end

	// Stall the host while a write is still waiting
	assign dl_ready_o = !pw_valid_o || pw_ready_i;
	assign accept     = dl_valid_i && dl_ready_o;
	assign dl_off     = dl_byte_i.offset;
	assign dl_rise    = dl_active_i && !active_q;
	assign dl_fall    = !dl_active_i && active_q;

	// Byte classification inside the chip packet area
	assign crt_body    = (kind == IMG_CRT) && (dl_off >= CRT_HDR_END);
	assign pkt_start   = crt_body && (blk_left == '0) && (hdr_cnt == '0);
	assign in_chip_hdr = crt_body && (hdr_cnt != '0);
	assign data_byte   = ((kind == IMG_PRG) && (dl_off >= ADDR_W'(2))) ||
		(crt_body && !pkt_start && !in_chip_hdr);

	// Round up to the next bank boundary unless already there
	assign aligned_addr = (wr_addr[BANK_ALIGN_W-1:0] == '0) ? wr_addr :
		{wr_addr[ADDR_W-1:BANK_ALIGN_W] + 1'b1, {BANK_ALIGN_W{1'b0}}};

	// ========================================================================
	// Control state
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_q        <= 1'b0;
			pw_valid_o      <= 1'b0;
			bank_valid_o    <= 1'b0;
			prg_done_o      <= 1'b0;
			cart_attached_o <= 1'b0;
			hdr_cnt         <= '0;
			blk_left        <= '0;
		end else begin
			active_q     <= dl_active_i;
			bank_valid_o <= 1'b0;
			prg_done_o   <= dl_fall && (kind == IMG_PRG);

			if (pw_ready_i)
				pw_valid_o <= 1'b0;

			if (dl_rise && kind == IMG_CRT) begin
				cart_attached_o <= 1'b0;
				hdr_cnt         <= '0;
				blk_left        <= '0;
			end
			if (dl_fall && kind == IMG_CRT)
				cart_attached_o <= 1'b1;

			if (accept) begin
				if (data_byte)
					pw_valid_o <= 1'b1;
				if (crt_body && data_byte)
					blk_left <= blk_left - 32'd1;
				// Counter wraps to zero after packet byte 15
				if (pkt_start || in_chip_hdr)
					hdr_cnt <= hdr_cnt + 4'd1;
				if (in_chip_hdr) begin
					case (hdr_cnt)
						4'd4:  blk_left[31:24] <= dl_byte_i.data;
						4'd5:  blk_left[23:16] <= dl_byte_i.data;
						4'd6:  blk_left[15:8]  <= dl_byte_i.data;
						4'd7:  blk_left[7:0]   <= dl_byte_i.data;
						// Length includes the packet header
						4'd8:  blk_left        <= blk_left - CHIP_HDR_LEN;
						4'd15: bank_valid_o    <= 1'b1;
						default: ;
					endcase
				end
			end
		end
	end

	// ========================================================================
	// Addresses, header fields and write payload
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			if (data_byte) begin
				pw_wr_o <= '{addr: wr_addr, data: dl_byte_i.data};
				wr_addr <= wr_addr + 1'b1;
			end

			if (kind == IMG_PRG) begin
				if (dl_off == '0) begin
					wr_addr         <= ADDR_W'(dl_byte_i.data);
					prg_end_o[7:0]  <= dl_byte_i.data;
				end else if (dl_off == ADDR_W'(1)) begin
					wr_addr         <= ADDR_W'({dl_byte_i.data, wr_addr[7:0]});
					prg_end_o[15:8] <= dl_byte_i.data;
				end else begin
					prg_end_o       <= prg_end_o + 16'd1;
				end
			end

			if (kind == IMG_CRT) begin
				case (dl_off)
					'h00: wr_addr           <= CRT_BASE;
					'h16: cart_info_o.id[15:8] <= dl_byte_i.data;
					'h17: cart_info_o.id[7:0]  <= dl_byte_i.data;
					'h18: cart_info_o.exrom    <= dl_byte_i.data;
					'h19: cart_info_o.game     <= dl_byte_i.data;
					default: ;
				endcase

				if (pkt_start) begin
					wr_addr         <= aligned_addr;
					bank_rec_o.base <= aligned_addr;
				end

				if (in_chip_hdr) begin
					case (hdr_cnt)
						4'd9:  bank_rec_o.chip_type       <= dl_byte_i.data;
						4'd10: bank_rec_o.bank[15:8]      <= dl_byte_i.data;
						4'd11: bank_rec_o.bank[7:0]       <= dl_byte_i.data;
						4'd12: bank_rec_o.load_addr[15:8] <= dl_byte_i.data;
						4'd13: bank_rec_o.load_addr[7:0]  <= dl_byte_i.data;
						4'd14: bank_rec_o.size[15:8]      <= dl_byte_i.data;
						4'd15: bank_rec_o.size[7:0]       <= dl_byte_i.data;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== src/basic_ptr_init.sv ====
// Page zero BASIC pointer writer
// Steps through the pointer list after a program download
// Data per address follows what a LOAD command leaves behind

module basic_ptr_init
	import loader_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_n,
	input  logic        prg_done_i,
	input  logic [15:0] prg_end_i,
	output logic        iw_valid_o,
	output mem_wr_t     iw_wr_o,
	input  logic        iw_ready_i,
	output logic        busy_o
);

	localparam int IDX_W = $clog2(BASIC_PTR_COUNT);

	logic [IDX_W-1:0] idx;
	logic [15:0]      end_q;
	logic [7:0]       ptr_addr;
	logic [7:0]       ptr_data;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy_o <= 1'b0;
			idx    <= '0;
		end else if (prg_done_i) begin
			busy_o <= 1'b1;
			idx    <= '0;
		end else if (busy_o && iw_ready_i) begin
			if (idx == IDX_W'(BASIC_PTR_COUNT - 1))
				busy_o <= 1'b0;
			else
				idx <= idx + 1'b1;
		end
	end

	// End address held for the whole sequence
	always_ff @(posedge clk_sys) begin
		if (prg_done_i)
			end_q <= prg_end_i;
	end

	always_comb begin
		ptr_addr = BASIC_PTR_ADDR[idx];
		case (ptr_addr)
			// Text start stays at its reset value
			8'h2B: ptr_data = 8'h01;
			8'h2C: ptr_data = 8'h08;
			// Variable, array, string and load end pointers
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_data = end_q[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_data = end_q[15:8];
			default: ptr_data = 8'h00;
		endcase
	end

	assign iw_valid_o = busy_o;
	assign iw_wr_o    = '{addr: ADDR_W'(ptr_addr), data: ptr_data};

endmodule

// ==== src/mem_write_port.sv ====
// Memory write port
// Fixed priority select between parser and pointer writer
// One entry output register that reloads while it drains

module mem_write_port
	import loader_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset_n,
	input  logic    pw_valid_i,
	input  mem_wr_t pw_wr_i,
	output logic    pw_ready_o,
	input  logic    iw_valid_i,
	input  mem_wr_t iw_wr_i,
	output logic    iw_ready_o,
	output logic    mem_valid_o,
	output mem_wr_t mem_wr_o,
	input  logic    mem_ready_i
);

	logic slot_open;

	// Register is empty or hands its write over this cycle
	assign slot_open = !mem_valid_o || mem_ready_i;

	// Parser wins over the pointer writer
	assign pw_ready_o = pw_valid_i && slot_open;
	assign iw_ready_o = iw_valid_i && !pw_valid_i && slot_open;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			mem_valid_o <= 1'b0;
		end else if (slot_open) begin
			mem_valid_o <= pw_valid_i || iw_valid_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pw_ready_o)
			mem_wr_o <= pw_wr_i;
		else if (iw_ready_o)
			mem_wr_o <= iw_wr_i;
	end

endmodule

// ==== src/image_loader_top.sv ====
// Image loader top level
// Parser, BASIC pointer writer and memory write port

module image_loader_top
	import loader_pkg::*;
#(
	parameter logic [ADDR_W-1:0] CRT_BASE = 25'h100000
) (
	input  logic       clk_sys,
	input  logic       reset_n,
	input  logic       dl_active_i,
	input  logic [7:0] dl_index_i,
	input  logic       dl_valid_i,
	input  dl_byte_t   dl_byte_i,
	output logic       dl_ready_o,
	output logic       mem_valid_o,
	output mem_wr_t    mem_wr_o,
	input  logic       mem_ready_i,
	output cart_info_t cart_info_o,
	output logic       cart_attached_o,
	output bank_rec_t  bank_rec_o,
	output logic       bank_valid_o,
	output logic       busy_o
);

	logic        pw_valid;
	mem_wr_t     pw_wr;
	logic        pw_ready;
	logic        iw_valid;
	mem_wr_t     iw_wr;
	logic        iw_ready;
	logic        prg_done;
	logic [15:0] prg_end;

	image_parser #(
		.CRT_BASE(CRT_BASE)
	) image_parser_i (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_valid_i     (dl_valid_i),
		.dl_byte_i      (dl_byte_i),
		.dl_ready_o     (dl_ready_o),
		.pw_valid_o     (pw_valid),
		.pw_wr_o        (pw_wr),
		.pw_ready_i     (pw_ready),
		.prg_done_o     (prg_done),
		.prg_end_o      (prg_end),
		.cart_info_o    (cart_info_o),
		.cart_attached_o(cart_attached_o),
		.bank_rec_o     (bank_rec_o),
		.bank_valid_o   (bank_valid_o)
	);

	basic_ptr_init basic_ptr_init_i (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.prg_done_i(prg_done),
		.prg_end_i (prg_end),
		.iw_valid_o(iw_valid),
		.iw_wr_o   (iw_wr),
		.iw_ready_i(iw_ready),
		.busy_o    (busy_o)
	);

	mem_write_port mem_write_port_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.pw_valid_i (pw_valid),
		.pw_wr_i    (pw_wr),
		.pw_ready_o (pw_ready),
		.iw_valid_i (iw_valid),
		.iw_wr_i    (iw_wr),
		.iw_ready_o (iw_ready),
		.mem_valid_o(mem_valid_o),
		.mem_wr_o   (mem_wr_o),
		.mem_ready_i(mem_ready_i)
	);

endmodule

// ==== verification/image_loader_props.sv ====
// Handshake assertions for the memory write port
// Valid and payload hold until ready on every channel
// A granted write shows in the output register on the next cycle

module image_loader_props
	import loader_pkg::*;
(
	input logic    clk_sys,
	input logic    reset_n,
	input logic    pw_valid_i,
	input mem_wr_t pw_wr_i,
	input logic    pw_ready_o,
	input logic    iw_valid_i,
	input mem_wr_t iw_wr_i,
	input logic    iw_ready_o,
	input logic    mem_valid_o,
	input mem_wr_t mem_wr_o,
	input logic    mem_ready_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// Output write holds while memory stalls
	mem_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_wr_o))
		else $error("mem_wr_o dropped or changed before mem_ready_i");

	parser_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		pw_valid_i && !pw_ready_o |=> pw_valid_i && $stable(pw_wr_i))
		else $error("parser write dropped or changed before its ready");

	pointer_hold: assert property (@(posedge clk_sys) disable iff (!reset_n)
		iw_valid_i && !iw_ready_o |=> iw_valid_i && $stable(iw_wr_i))
		else $error("pointer write dropped or changed before its ready");

	// Accepted writes reach memory unchanged
	parser_to_mem: assert property (@(posedge clk_sys) disable iff (!reset_n)
		pw_ready_o |=> mem_valid_o && (mem_wr_o == $past(pw_wr_i)))
		else $error("granted parser write missing from the output register");

	pointer_to_mem: assert property (@(posedge clk_sys) disable iff (!reset_n)
		iw_ready_o |=> mem_valid_o && (mem_wr_o == $past(iw_wr_i)))
		else $error("granted pointer write missing from the output register");

endmodule

bind mem_write_port image_loader_props mem_write_port_props_i (
	.clk_sys    (clk_sys),
	.reset_n    (reset_n),
	.pw_valid_i (pw_valid_i),
	.pw_wr_i    (pw_wr_i),
	.pw_ready_o (pw_ready_o),
	.iw_valid_i (iw_valid_i),
	.iw_wr_i    (iw_wr_i),
	.iw_ready_o (iw_ready_o),
	.mem_valid_o(mem_valid_o),
	.mem_wr_o   (mem_wr_o),
	.mem_ready_i(mem_ready_i)
);

// ==== verification/image_loader_tb.sv ====
// Testbench for the image loader
// Clock, reset and a memory model with selectable stall patterns
// Directed tests for reset state, PRG data, BASIC pointers, CRT banks
// and a PRG replay under heavy back-pressure

module image_loader_tb
	import loader_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [ADDR_W-1:0] CRT_BASE = 25'h100000;
	localparam int          MAX_CYCLES = 4000;
	localparam int          SEED       = 44706;
	localparam int          PRG_LEN    = 40;
	localparam logic [15:0] PRG_LOAD   = 16'h0801;
	localparam logic [15:0] CART_ID    = 16'h0013;
	localparam logic [7:0]  CART_EXROM = 8'h01;
	localparam logic [7:0]  CART_GAME  = 8'h00;
	// Page zero pointers in the order they are written
	localparam logic [7:0] PTR_LIST [12] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E, 8'h2F, 8'h30,
		8'h31, 8'h32, 8'hAC, 8'hAD, 8'hAE, 8'hAF
	};

	logic       clk_sys;
	logic       reset_n;
	logic       dl_active_i;
	logic [7:0] dl_index_i;
	logic       dl_valid_i;
	dl_byte_t   dl_byte_i;
	logic       dl_ready_o;
	logic       mem_valid_o;
	mem_wr_t    mem_wr_o;
	logic       mem_ready_i;
	cart_info_t cart_info_o;
	logic       cart_attached_o;
	bank_rec_t  bank_rec_o;
	logic       bank_valid_o;
	logic       busy_o;

	int          errors;
	int          tests;
	int          cycles;
	int          stall_mode;
	int          stretch;
	logic [7:0]  img [$];
	mem_wr_t     wr_log [$];
	mem_wr_t     exp_log [$];
	bank_rec_t   bank_log [$];
	bank_rec_t   exp_banks [2];
	logic [7:0]  mem_model [logic [ADDR_W-1:0]];

	image_loader_top #(
		.CRT_BASE(CRT_BASE)
	) image_loader_top_i (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_valid_i     (dl_valid_i),
		.dl_byte_i      (dl_byte_i),
		.dl_ready_o     (dl_ready_o),
		.mem_valid_o    (mem_valid_o),
		.mem_wr_o       (mem_wr_o),
		.mem_ready_i    (mem_ready_i),
		.cart_info_o    (cart_info_o),
		.cart_attached_o(cart_attached_o),
		.bank_rec_o     (bank_rec_o),
		.bank_valid_o   (bank_valid_o),
		.busy_o         (busy_o)
	);

	always #10 clk_sys = ~clk_sys;

	// ========================================================================
	// Memory model, stall patterns and timeout
	// ========================================================================

	// Mode 0 never stalls, 1 stalls at random, 2 holds ready low for long runs
	always @(posedge clk_sys) begin
		#2;
		case (stall_mode)
			0: mem_ready_i = 1'b1;
			1: mem_ready_i = ($urandom % 4) != 0;
			default: begin
				if (stretch > 0) begin
					stretch = stretch - 1;
				end else if (mem_ready_i) begin
					mem_ready_i = 1'b0;
					stretch     = 8 + ($urandom % 16);
				end else begin
					mem_ready_i = 1'b1;
					stretch     = $urandom % 3;
				end
			end
		endcase
	end

	// Mid-cycle sampling, the transfer itself happens at the next edge
	always @(negedge clk_sys) begin
		if (reset_n && mem_valid_o && mem_ready_i) begin
			wr_log.push_back(mem_wr_o);
			mem_model[mem_wr_o.addr] = mem_wr_o.data;
		end
		if (reset_n && bank_valid_o)
			bank_log.push_back(bank_rec_o);
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	// ========================================================================
	// Helpers
	// ========================================================================

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors = errors + 1;
	endtask

	task automatic report_failure(input string what);
		$display("Failure: %s", what);
		errors = errors + 1;
	endtask

	function automatic logic [7:0] data_pattern(input int k);
		return 8'(k * 29 + 90);
	endfunction

	// Value a LOAD command leaves in each page zero pointer
	function automatic logic [7:0] ptr_value(input logic [7:0] addr,
		input logic [15:0] end_addr);
		case (addr)
			8'h2B: return 8'h01;
			8'h2C: return 8'h08;
			8'hAC, 8'hAD: return 8'h00;
			8'h2D, 8'h2F, 8'h31, 8'hAE: return end_addr[7:0];
			default: return end_addr[15:8];
		endcase
	endfunction

	function automatic logic [7:0] crt_header_byte(input int i);
		case (i)
			'h16: return CART_ID[15:8];
			'h17: return CART_ID[7:0];
			'h18: return CART_EXROM;
			'h19: return CART_GAME;
			default: return 8'(i + 3);
		endcase
	endfunction

	task automatic clear_logs();
		wr_log.delete();
		bank_log.delete();
		mem_model.delete();
	endtask

	// Holds the byte until the DUT takes it, ends 2 ns after that edge
	task automatic send_byte(input logic [ADDR_W-1:0] off, input logic [7:0] data);
		logic taken;
		dl_byte_i.offset = off;
		dl_byte_i.data   = data;
		dl_valid_i       = 1'b1;
		taken            = 1'b0;
		while (!taken) begin
			@(negedge clk_sys);
			taken = dl_ready_o;
			@(posedge clk_sys);
			#2;
		end
		dl_valid_i = 1'b0;
	endtask

	task automatic load_image(input logic [7:0] index);
		@(posedge clk_sys);
		#2;
		dl_index_i  = index;
		dl_active_i = 1'b1;
		@(posedge clk_sys);
		#2;
		for (int i = 0; i < img.size(); i++)
			send_byte(ADDR_W'(i), img[i]);
		dl_active_i = 1'b0;
	endtask

	task automatic build_prg();
		mem_wr_t     w;
		logic [15:0] end_addr;
		img.delete();
		exp_log.delete();
		img.push_back(PRG_LOAD[7:0]);
		img.push_back(PRG_LOAD[15:8]);
		for (int k = 0; k < PRG_LEN; k++) begin
			w.addr = ADDR_W'(PRG_LOAD) + ADDR_W'(k);
			w.data = data_pattern(k);
			img.push_back(w.data);
			exp_log.push_back(w);
		end
		end_addr = PRG_LOAD + 16'(PRG_LEN);
		for (int i = 0; i < 12; i++) begin
			w.addr = ADDR_W'(PTR_LIST[i]);
			w.data = ptr_value(PTR_LIST[i], end_addr);
			exp_log.push_back(w);
		end
	endtask

	// Chip packet: signature, length with header, type, bank, load, size
	task automatic add_packet(input int slot, input logic [7:0] chip_type,
		input logic [15:0] bank, input logic [15:0] load, input logic [15:0] size,
		input logic [ADDR_W-1:0] base);
		logic [31:0] len;
		mem_wr_t     w;
		len = 32'(size) + 32'd16;
		img.push_back(8'h43);
		img.push_back(8'h48);
		img.push_back(8'h49);
		img.push_back(8'h50);
		img.push_back(len[31:24]);
		img.push_back(len[23:16]);
		img.push_back(len[15:8]);
		img.push_back(len[7:0]);
		img.push_back(8'h00);
		img.push_back(chip_type);
		img.push_back(bank[15:8]);
		img.push_back(bank[7:0]);
		img.push_back(load[15:8]);
		img.push_back(load[7:0]);
		img.push_back(size[15:8]);
		img.push_back(size[7:0]);
		for (int j = 0; j < int'(size); j++) begin
			w.addr = base + ADDR_W'(j);
			w.data = data_pattern(slot * 64 + j + 7);
			img.push_back(w.data);
			exp_log.push_back(w);
		end
		exp_banks[slot].chip_type = chip_type;
		exp_banks[slot].bank      = bank;
		exp_banks[slot].load_addr = load;
		exp_banks[slot].size      = size;
		exp_banks[slot].base      = base;
	endtask

	task automatic compare_writes(input string tag);
		if (wr_log.size() != exp_log.size())
			report_mismatch({tag, " write count"}, wr_log.size(), exp_log.size());
		for (int i = 0; i < wr_log.size() && i < exp_log.size(); i++) begin
			if (wr_log[i].addr != exp_log[i].addr)
				report_mismatch({tag, " mem_wr_o.addr"}, wr_log[i].addr, exp_log[i].addr);
			if (wr_log[i].data != exp_log[i].data)
				report_mismatch({tag, " mem_wr_o.data"}, wr_log[i].data, exp_log[i].data);
		end
	endtask

	// The last pointer write must sit in the port when busy_o drops
	task automatic wait_pointer_sequence();
		do begin
			@(negedge clk_sys);
		end while (!busy_o);
		do begin
			@(negedge clk_sys);
		end while (busy_o);
		if (!mem_valid_o)
			report_failure("busy_o fell with no pointer write held in the port");
		else if (mem_wr_o.addr != ADDR_W'(8'hAF))
			report_mismatch("mem_wr_o.addr at busy_o fall", mem_wr_o.addr, 8'hAF);
		do begin
			@(negedge clk_sys);
		end while (mem_valid_o);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic check_reset_state();
		tests = tests + 1;
		@(negedge clk_sys);
		if (mem_valid_o !== 1'b0)
			report_mismatch("mem_valid_o", mem_valid_o, 0);
		if (bank_valid_o !== 1'b0)
			report_mismatch("bank_valid_o", bank_valid_o, 0);
		if (cart_attached_o !== 1'b0)
			report_mismatch("cart_attached_o", cart_attached_o, 0);
		if (busy_o !== 1'b0)
			report_mismatch("busy_o", busy_o, 0);
		if (dl_ready_o !== 1'b1)
			report_mismatch("dl_ready_o", dl_ready_o, 1);
	endtask

	task automatic load_prg_and_pointers();
		tests      = tests + 1;
		stall_mode = 0;
		clear_logs();
		build_prg();
		load_image(8'h04);
		wait_pointer_sequence();
		compare_writes("PRG");
	endtask

	task automatic load_crt_banks();
		tests      = tests + 1;
		stall_mode = 1;
		clear_logs();
		img.delete();
		exp_log.delete();
		for (int i = 0; i < 64; i++)
			img.push_back(crt_header_byte(i));
		add_packet(0, 8'h00, 16'h0000, 16'h8000, 16'd20, CRT_BASE);
		add_packet(1, 8'h02, 16'h0001, 16'hA000, 16'd8, CRT_BASE + 25'h2000);
		load_image(8'h05);
		if (cart_attached_o !== 1'b0)
			report_mismatch("cart_attached_o during download", cart_attached_o, 0);
		do begin
			@(negedge clk_sys);
		end while (!cart_attached_o);
		do begin
			@(negedge clk_sys);
		end while (wr_log.size() < exp_log.size());
		// Short settle so that a stray extra write would show up
		repeat (4) @(negedge clk_sys);
		compare_writes("CRT");
		foreach (exp_log[i]) begin
			if (!mem_model.exists(exp_log[i].addr))
				report_failure("cartridge byte missing from memory");
			else if (mem_model[exp_log[i].addr] != exp_log[i].data)
				report_mismatch("memory data", mem_model[exp_log[i].addr], exp_log[i].data);
		end
		if (cart_info_o.id != CART_ID)
			report_mismatch("cart_info_o.id", cart_info_o.id, CART_ID);
		if (cart_info_o.exrom != CART_EXROM)
			report_mismatch("cart_info_o.exrom", cart_info_o.exrom, CART_EXROM);
		if (cart_info_o.game != CART_GAME)
			report_mismatch("cart_info_o.game", cart_info_o.game, CART_GAME);
		if (bank_log.size() != 2)
			report_mismatch("bank_valid_o strobes", bank_log.size(), 2);
		for (int i = 0; i < bank_log.size() && i < 2; i++) begin
			if (bank_log[i].chip_type != exp_banks[i].chip_type)
				report_mismatch("bank_rec_o.chip_type", bank_log[i].chip_type,
					exp_banks[i].chip_type);
			if (bank_log[i].bank != exp_banks[i].bank)
				report_mismatch("bank_rec_o.bank", bank_log[i].bank, exp_banks[i].bank);
			if (bank_log[i].load_addr != exp_banks[i].load_addr)
				report_mismatch("bank_rec_o.load_addr", bank_log[i].load_addr,
					exp_banks[i].load_addr);
			if (bank_log[i].size != exp_banks[i].size)
				report_mismatch("bank_rec_o.size", bank_log[i].size, exp_banks[i].size);
			if (bank_log[i].base != exp_banks[i].base)
				report_mismatch("bank_rec_o.base", bank_log[i].base, exp_banks[i].base);
		end
	endtask

	// Same image and same expected order as the stall-free run
	task automatic replay_under_stalls();
		tests      = tests + 1;
		stall_mode = 2;
		clear_logs();
		build_prg();
		load_image(8'h04);
		wait_pointer_sequence();
		compare_writes("replay");
		stall_mode = 0;
	endtask

	initial begin
		clk_sys     = 1'b0;
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = 8'h00;
		dl_valid_i  = 1'b0;
		dl_byte_i   = '0;
		mem_ready_i = 1'b1;
		errors      = 0;
		tests       = 0;
		cycles      = 0;
		stall_mode  = 0;
		stretch     = 0;
		void'($urandom(SEED));
		repeat (2) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;

		check_reset_state();
		load_prg_and_pointers();
		load_crt_banks();
		replay_under_stalls();

		$display("Run complete: %0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== compile.f ====
src/loader_pkg.sv
src/image_parser.sv
src/basic_ptr_init.sv
src/mem_write_port.sv
src/image_loader_top.sv
verification/image_loader_props.sv
verification/image_loader_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the image loader testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=image_loader_tb

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module "$TOP" -f compile.f -o "V$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

echo "No failure found in $LOG"
exit 0
